//--- hdl/spi_wb_pkg.sv
package spi_wb_pkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [15:0] adr; // Word address
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t;

  // Command byte is {we, 3'b000, sel[3:0]}
  localparam int CMD_WE_BIT  = 7;
  localparam int CMD_SEL_LSB = 0;

  localparam int ADDR_BYTES = 2; // High byte first
  localparam int DATA_BYTES = 4; // Most significant byte first

  localparam logic [7:0] STATUS_PENDING = 8'h00;
  localparam logic [7:0] STATUS_ACK     = 8'h01;
  localparam logic [7:0] STATUS_ERR     = 8'h02;

  localparam logic [15:0] SYS_BASE = 16'h0000;
  localparam logic [15:0] SYS_HIGH = 16'h00FF;
  localparam logic [15:0] EXT_BASE = 16'h0100;
  localparam logic [15:0] EXT_HIGH = 16'h01FF;

  // A byte on the SPI side must outlast this plus a few cycles of sync delay
  localparam int WB_TIMEOUT_CYCLES = 32;
  localparam int TIMER_W           = 6;

  localparam logic [31:0] BOARD_ID = 32'd12;
  localparam logic [31:0] REV_WORD = 32'h0001_0000; // Major 1, minor 0

  localparam logic [7:0] REG_ID      = 8'd0;
  localparam logic [7:0] REG_REV     = 8'd1;
  localparam logic [7:0] REG_SCRATCH = 8'd2;
  localparam logic [7:0] REG_DEBUG   = 8'd3;

endpackage

//--- hdl/spi_frame_shifter.sv
module spi_frame_shifter (
  input  logic       sys_clk,
  input  logic       reset_i,
  input  logic       cs_n_i,
  input  logic       sclk_i,
  input  logic       mosi_i,
  output logic       miso_o,
  output logic [7:0] rx_byte_o,
  output logic       rx_byte_stb_o,
  output logic       frame_start_stb_o,
  output logic       frame_end_stb_o,
  input  logic [7:0] tx_byte_i,
  input  logic       tx_load_stb_i
);

  logic [2:0] cs_sync;   // Third stage only feeds the edge detect
  logic [2:0] sclk_sync;
  logic [1:0] mosi_sync;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_fall;
  logic       cs_rise;
  logic       selected;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;
  logic [7:0] tx_next;

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      cs_sync   <= '1;
      sclk_sync <= '0;
      mosi_sync <= '0;
    end else begin
      cs_sync   <= {cs_sync[1:0], cs_n_i};
      sclk_sync <= {sclk_sync[1:0], sclk_i};
      mosi_sync <= {mosi_sync[0], mosi_i};
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign cs_fall   = ~cs_sync[1] & cs_sync[2];
  assign cs_rise   = cs_sync[1] & ~cs_sync[2];
  assign selected  = ~cs_sync[1];

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      bit_cnt           <= '0;
      rx_byte_stb_o     <= 1'b0;
      frame_start_stb_o <= 1'b0;
      frame_end_stb_o   <= 1'b0;
    end else begin
      rx_byte_stb_o     <= 1'b0;
      frame_start_stb_o <= cs_fall;
      frame_end_stb_o   <= cs_rise;
      if (!selected) begin
        bit_cnt <= '0;
      end else if (sclk_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) rx_byte_stb_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sclk_rise) rx_shift <= {rx_shift[6:0], mosi_sync[1]};
  end

  assign rx_byte_o = rx_shift;

  // The falling edge that closes a byte presents the MSB of the queued one
  always_ff @(posedge sys_clk) begin
    if (reset_i || !selected) begin
      tx_shift <= '0;
      tx_next  <= '0;
    end else begin
      if (sclk_fall) begin
        if (bit_cnt == 3'd0) tx_shift <= tx_next;
        else tx_shift <= {tx_shift[6:0], 1'b0};
      end
      if (tx_load_stb_i) begin
        tx_next <= tx_byte_i;
      end else if (sclk_fall && bit_cnt == 3'd0) begin
        tx_next <= '0; // Bytes nobody queued go out as zero
      end
    end
  end

  assign miso_o = tx_shift[7] & ~cs_n_i;

endmodule

//--- hdl/spi_bridge_fsm.sv
module spi_bridge_fsm (
  input  logic                sys_clk,
  input  logic                reset_i,
  input  logic [7:0]          rx_byte_i,
  input  logic                rx_byte_stb_i,
  input  logic                frame_start_stb_i,
  input  logic                frame_end_stb_i,
  output logic [7:0]          tx_byte_o,
  output logic                tx_load_stb_o,
  output spi_wb_pkg::wb_req_t wb_req_o,
  input  spi_wb_pkg::wb_rsp_t wb_rsp_i,
  output logic                cmd_done_stb_o
);
  import spi_wb_pkg::*;

  typedef enum logic [3:0] {
    IDLE, CMD, ADDR, WDATA, BUS, TURN, STATUS, RDATA, DONE
  } state_e;

  state_e      state_q;
  logic [1:0]  byte_cnt;
  logic        we_q;
  logic [3:0]  sel_q;
  logic [15:0] addr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;
  logic [7:0]  status_q;
  logic        abort_q;
  logic        rsp_done;
  logic [15:0] next_addr;
  logic [31:0] next_wdata;
  wb_req_t     req_q;

  assign rsp_done   = wb_rsp_i.ack | wb_rsp_i.err;
  assign next_addr  = {addr_q[7:0], rx_byte_i};
  assign next_wdata = {wdata_q[23:0], rx_byte_i};

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      state_q        <= IDLE;
      byte_cnt       <= '0;
      abort_q        <= 1'b0;
      req_q.cyc      <= 1'b0;
      req_q.stb      <= 1'b0;
      tx_load_stb_o  <= 1'b0;
      cmd_done_stb_o <= 1'b0;
    end else begin
      tx_load_stb_o  <= 1'b0;
      cmd_done_stb_o <= 1'b0;
      if (state_q == BUS) begin
        // An issued request always runs to its end, even if cs_n rises
        if (frame_end_stb_i) abort_q <= 1'b1;
        if (rsp_done) begin
          req_q.cyc      <= 1'b0;
          req_q.stb      <= 1'b0;
          cmd_done_stb_o <= 1'b1;
          status_q       <= wb_rsp_i.err ? STATUS_ERR : STATUS_ACK;
          rdata_q        <= wb_rsp_i.dat;
          state_q        <= (abort_q || frame_end_stb_i) ? IDLE : TURN;
        end
      end else if (frame_end_stb_i) begin
        state_q <= IDLE;
      end else if (frame_start_stb_i) begin
        state_q <= CMD;
        abort_q <= 1'b0;
      end else if (rx_byte_stb_i) begin
        case (state_q)
          CMD: begin
            we_q     <= rx_byte_i[CMD_WE_BIT];
            sel_q    <= rx_byte_i[CMD_SEL_LSB +: 4];
            byte_cnt <= '0;
            state_q  <= ADDR;
          end
          ADDR: begin
            addr_q   <= next_addr;
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'(ADDR_BYTES - 1)) begin
              byte_cnt <= '0;
              if (we_q) begin
                state_q <= WDATA;
              end else begin
                req_q    <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: sel_q,
                              adr: next_addr, dat: wdata_q};
                status_q <= STATUS_PENDING;
                state_q  <= BUS;
              end
            end
          end
          WDATA: begin
            wdata_q  <= next_wdata;
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'(DATA_BYTES - 1)) begin
              req_q    <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, sel: sel_q,
                            adr: addr_q, dat: next_wdata};
              status_q <= STATUS_PENDING;
              state_q  <= BUS;
            end
          end
          TURN: begin
            tx_byte_o     <= status_q;
            tx_load_stb_o <= 1'b1;
            state_q       <= STATUS;
          end
          STATUS: begin
            if (we_q) begin
              state_q <= DONE;
            end else begin
              tx_byte_o     <= rdata_q[31:24];
              tx_load_stb_o <= 1'b1;
              rdata_q       <= {rdata_q[23:0], 8'h00};
              byte_cnt      <= '0;
              state_q       <= RDATA;
            end
          end
          RDATA: begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'(DATA_BYTES - 1)) begin
              state_q <= DONE;
            end else begin
              tx_byte_o     <= rdata_q[31:24]; // Next byte is queued while this one goes out
              tx_load_stb_o <= 1'b1;
              rdata_q       <= {rdata_q[23:0], 8'h00};
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign wb_req_o = req_q;

endmodule

//--- hdl/wb_timeout_timer.sv
module wb_timeout_timer (
  input  logic sys_clk,
  input  logic reset_i,
  input  logic busy_i,
  output logic expired_o
);
  import spi_wb_pkg::*;

  logic [TIMER_W-1:0] count_q;

  // Restarts from zero for every new request
  always_ff @(posedge sys_clk) begin
    if (reset_i || !busy_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  assign expired_o = busy_i && (count_q == TIMER_W'(WB_TIMEOUT_CYCLES - 1));

endmodule

//--- hdl/wb_addr_decoder.sv
module wb_addr_decoder (
  input  logic                sys_clk,
  input  logic                reset_i,
  input  spi_wb_pkg::wb_req_t m_req_i,
  output spi_wb_pkg::wb_rsp_t m_rsp_o,
  output spi_wb_pkg::wb_req_t sys_req_o,
  output spi_wb_pkg::wb_req_t ext_req_o,
  input  spi_wb_pkg::wb_rsp_t sys_rsp_i,
  input  spi_wb_pkg::wb_rsp_t ext_rsp_i,
  output logic                busy_o,
  input  logic                expired_i
);
  import spi_wb_pkg::*;

  typedef enum logic [1:0] {RGN_NONE, RGN_SYS, RGN_EXT} rgn_e;

  rgn_e rgn_q;
  logic active_q;
  logic err_q;
  logic m_valid;

  function automatic logic in_range(input logic [15:0] adr, input logic [15:0] base,
                                    input logic [15:0] high);
    return 16'(adr - base) <= 16'(high - base);
  endfunction

  assign m_valid = m_req_i.cyc & m_req_i.stb;

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      active_q <= 1'b0;
      rgn_q    <= RGN_NONE;
      err_q    <= 1'b0;
    end else begin
      err_q <= 1'b0;
      if (!active_q) begin
        if (m_valid) begin
          active_q <= 1'b1;
          if (in_range(m_req_i.adr, SYS_BASE, SYS_HIGH)) begin
            rgn_q <= RGN_SYS;
          end else if (in_range(m_req_i.adr, EXT_BASE, EXT_HIGH)) begin
            rgn_q <= RGN_EXT;
          end else begin
            rgn_q <= RGN_NONE;
            err_q <= 1'b1; // Unmapped
          end
        end
      end else if (m_rsp_o.ack || m_rsp_o.err) begin
        active_q <= 1'b0;
        rgn_q    <= RGN_NONE;
      end else if (expired_i) begin
        rgn_q <= RGN_NONE; // Withdraw cyc from the stalled region
        err_q <= 1'b1;
      end
    end
  end

  always_comb begin
    sys_req_o     = m_req_i;
    ext_req_o     = m_req_i;
    sys_req_o.cyc = m_req_i.cyc & (rgn_q == RGN_SYS);
    sys_req_o.stb = m_req_i.stb & (rgn_q == RGN_SYS);
    ext_req_o.cyc = m_req_i.cyc & (rgn_q == RGN_EXT);
    ext_req_o.stb = m_req_i.stb & (rgn_q == RGN_EXT);
  end

  always_comb begin
    case (rgn_q)
      RGN_SYS: m_rsp_o = sys_rsp_i;
      RGN_EXT: m_rsp_o = ext_rsp_i;
      default: m_rsp_o = '0;
    endcase
    if (err_q) m_rsp_o.err = 1'b1;
  end

  assign busy_o = active_q && (rgn_q != RGN_NONE);

endmodule

//--- hdl/sys_block.sv
module sys_block (
  input  logic                sys_clk,
  input  logic                reset_i,
  input  spi_wb_pkg::wb_req_t req_i,
  output spi_wb_pkg::wb_rsp_t rsp_o,
  output logic [31:0]         debug_o
);
  import spi_wb_pkg::*;

  logic [7:0]  reg_idx;
  logic        req_valid;
  logic        ack_q;
  logic [31:0] rdat_q;
  logic [31:0] scratch_q;
  logic [31:0] debug_q;

  function automatic logic [31:0] merge_lanes(input logic [31:0] cur, input logic [31:0] wr,
                                              input logic [3:0] sel);
    logic [31:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) res[8*i +: 8] = wr[8*i +: 8];
    end
    return res;
  endfunction

  assign reg_idx   = req_i.adr[7:0];
  assign req_valid = req_i.cyc & req_i.stb & ~ack_q; // One ack per request

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      ack_q     <= 1'b0;
      scratch_q <= '0;
      debug_q   <= '0;
    end else begin
      ack_q <= req_valid;
      if (req_valid && req_i.we) begin
        case (reg_idx)
          REG_SCRATCH: scratch_q <= merge_lanes(scratch_q, req_i.dat, req_i.sel);
          REG_DEBUG:   debug_q   <= merge_lanes(debug_q, req_i.dat, req_i.sel);
          default: ; // ID and revision are constants
        endcase
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (req_valid) begin
      case (reg_idx)
        REG_ID:      rdat_q <= BOARD_ID;
        REG_REV:     rdat_q <= REV_WORD;
        REG_SCRATCH: rdat_q <= scratch_q;
        REG_DEBUG:   rdat_q <= debug_q;
        default:     rdat_q <= '0;
      endcase
    end
  end

  assign rsp_o   = '{ack: ack_q, err: 1'b0, dat: rdat_q};
  assign debug_o = debug_q;

endmodule

//--- hdl/spi_wb_top.sv
module spi_wb_top (
  input  logic                sys_clk,
  input  logic                reset_i,
  input  logic                spi_cs_n_i,
  input  logic                spi_sclk_i,
  input  logic                spi_mosi_i,
  output logic                spi_miso_o,
  output spi_wb_pkg::wb_req_t ext_req_o,
  input  spi_wb_pkg::wb_rsp_t ext_rsp_i,
  output logic [31:0]         debug_o,
  output logic                cmd_done_stb_o
);
  import spi_wb_pkg::*;

  logic [7:0] rx_byte;
  logic [7:0] tx_byte;
  logic       rx_byte_stb;
  logic       frame_start_stb;
  logic       frame_end_stb;
  logic       tx_load_stb;
  logic       busy;
  logic       expired;
  wb_req_t    m_req;
  wb_rsp_t    m_rsp;
  wb_req_t    sys_req;
  wb_rsp_t    sys_rsp;

  spi_frame_shifter u_shifter (
    .sys_clk          (sys_clk),
    .reset_i          (reset_i),
    .cs_n_i           (spi_cs_n_i),
    .sclk_i           (spi_sclk_i),
    .mosi_i           (spi_mosi_i),
    .miso_o           (spi_miso_o),
    .rx_byte_o        (rx_byte),
    .rx_byte_stb_o    (rx_byte_stb),
    .frame_start_stb_o(frame_start_stb),
    .frame_end_stb_o  (frame_end_stb),
    .tx_byte_i        (tx_byte),
    .tx_load_stb_i    (tx_load_stb)
  );

  spi_bridge_fsm u_fsm (
    .sys_clk          (sys_clk),
    .reset_i          (reset_i),
    .rx_byte_i        (rx_byte),
    .rx_byte_stb_i    (rx_byte_stb),
    .frame_start_stb_i(frame_start_stb),
    .frame_end_stb_i  (frame_end_stb),
    .tx_byte_o        (tx_byte),
    .tx_load_stb_o    (tx_load_stb),
    .wb_req_o         (m_req),
    .wb_rsp_i         (m_rsp),
    .cmd_done_stb_o   (cmd_done_stb_o)
  );

  wb_addr_decoder u_decoder (
    .sys_clk  (sys_clk),
    .reset_i  (reset_i),
    .m_req_i  (m_req),
    .m_rsp_o  (m_rsp),
    .sys_req_o(sys_req),
    .ext_req_o(ext_req_o),
    .sys_rsp_i(sys_rsp),
    .ext_rsp_i(ext_rsp_i),
    .busy_o   (busy),
    .expired_i(expired)
  );

  wb_timeout_timer u_timer (
    .sys_clk  (sys_clk),
    .reset_i  (reset_i),
    .busy_i   (busy),
    .expired_o(expired)
  );

  sys_block u_sys_block (
    .sys_clk(sys_clk),
    .reset_i(reset_i),
    .req_i  (sys_req),
    .rsp_o  (sys_rsp),
    .debug_o(debug_o)
  );

endmodule

//--- dv/spi_wb_tb.sv
module spi_wb_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import spi_wb_pkg::*;

  localparam int FRAME_COUNT     = 142;
  localparam int WATCHDOG_CYCLES = FRAME_COUNT * 12 * 64 + 1000;
  localparam int EXT_ACK         = 0;
  localparam int EXT_ERR         = 1;
  localparam int EXT_HANG        = 2;

  logic        sys_clk;
  logic        reset;
  logic        spi_cs_n;
  logic        spi_sclk;
  logic        spi_mosi;
  logic        spi_miso;
  wb_req_t     ext_req;
  wb_rsp_t     ext_rsp;
  logic [31:0] debug;
  logic        cmd_done;

  int          mismatch_count = 0;
  int          failure_count = 0;
  int          done_count = 0;
  int          ext_seen = 0;
  logic        ext_expect = 1'b0;
  int          ext_mode = EXT_ACK;
  int          ext_delay = 1;
  logic [15:0] ext_exp_adr;
  logic        ext_exp_we;
  logic [3:0]  ext_exp_sel;
  logic [31:0] ext_exp_dat;
  logic [31:0] ext_mem [256];   // Storage behind the external slave
  logic [31:0] ext_model [256];
  logic [31:0] model_scratch = '0;
  logic [31:0] model_debug = '0;

  spi_wb_top DUT (
    .sys_clk       (sys_clk),
    .reset_i       (reset),
    .spi_cs_n_i    (spi_cs_n),
    .spi_sclk_i    (spi_sclk),
    .spi_mosi_i    (spi_mosi),
    .spi_miso_o    (spi_miso),
    .ext_req_o     (ext_req),
    .ext_rsp_i     (ext_rsp),
    .debug_o       (debug),
    .cmd_done_stb_o(cmd_done)
  );

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;
  end

  task automatic report_mismatch(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    mismatch_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    failure_count++;
  endtask

  function automatic logic [31:0] lane_write(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic logic [31:0] ext_fill(input int idx);
    logic [7:0] a;
    a = 8'(idx);
    return {a ^ 8'h5A, ~a, a, a + 8'h33};
  endfunction

  // Mode 0 bit transfer with mosi set while sclk is low and miso taken just before the rise
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      spi_mosi = tx[i];
      repeat (4) @(negedge sys_clk);
      rx[i]    = spi_miso;
      spi_sclk = 1'b1;
      repeat (4) @(negedge sys_clk);
      spi_sclk = 1'b0;
    end
  endtask

  task automatic spi_frame(input logic we, input logic [3:0] sel, input logic [15:0] adr,
                           input logic [31:0] wdata, output logic [7:0] status,
                           output logic [31:0] rdata);
    logic [7:0] cmd;
    logic [7:0] rx;
    logic [7:0] quiet;
    cmd = 8'h00;
    cmd[CMD_WE_BIT] = we;
    cmd[CMD_SEL_LSB +: 4] = sel;
    rdata = '0;
    spi_cs_n = 1'b0;
    repeat (4) @(negedge sys_clk);
    spi_byte(cmd, rx);
    quiet = rx;
    spi_byte(adr[15:8], rx);
    quiet = quiet | rx;
    spi_byte(adr[7:0], rx);
    quiet = quiet | rx;
    if (we) begin
      for (int i = 3; i >= 0; i--) spi_byte(wdata[8*i +: 8], rx);
    end
    spi_byte(8'h00, rx); // Turnaround
    quiet = quiet | rx;
    if (quiet !== 8'h00) report_mismatch($sformatf("miso not idle in header, got 0x%02h", quiet));
    if (ext_req.cyc !== 1'b0) report_mismatch("ext cyc still high when the status byte starts");
    spi_byte(8'h00, status);
    if (!we) begin
      for (int i = 3; i >= 0; i--) begin
        spi_byte(8'h00, rx);
        rdata[8*i +: 8] = rx;
      end
    end
    repeat (4) @(negedge sys_clk);
    spi_cs_n = 1'b1;
    repeat (8) @(negedge sys_clk);
  endtask

  task automatic run_access(input logic we, input logic [3:0] sel, input logic [15:0] adr,
                            input logic [31:0] wdata, input int mode);
    logic [7:0]  status;
    logic [31:0] rdata;
    logic [7:0]  exp_status;
    logic [31:0] exp_rdata;
    logic        is_ext;
    int          done_before;
    is_ext    = (adr >= EXT_BASE) && (adr <= EXT_HIGH);
    exp_rdata = '0;
    if (adr <= SYS_HIGH) begin
      exp_status = STATUS_ACK;
      case (adr[7:0])
        REG_ID:      exp_rdata = BOARD_ID;
        REG_REV:     exp_rdata = REV_WORD;
        REG_SCRATCH: exp_rdata = model_scratch;
        REG_DEBUG:   exp_rdata = model_debug;
        default:     exp_rdata = '0;
      endcase
      if (we && adr[7:0] == REG_SCRATCH) model_scratch = lane_write(model_scratch, wdata, sel);
      if (we && adr[7:0] == REG_DEBUG) model_debug = lane_write(model_debug, wdata, sel);
    end else if (is_ext) begin
      exp_status = (mode == EXT_ACK) ? STATUS_ACK : STATUS_ERR;
      exp_rdata  = ext_model[adr[7:0]];
      if (we && mode == EXT_ACK) begin
        ext_model[adr[7:0]] = lane_write(ext_model[adr[7:0]], wdata, sel);
      end
    end else begin
      exp_status = STATUS_ERR; // Unmapped
    end
    ext_expect  = is_ext;
    ext_mode    = mode;
    ext_delay   = $urandom_range(20, 1);
    ext_exp_adr = adr;
    ext_exp_we  = we;
    ext_exp_sel = sel;
    ext_exp_dat = wdata;
    ext_seen    = 0;
    done_before = done_count;
    spi_frame(we, sel, adr, wdata, status, rdata);
    if (status !== exp_status) begin
      report_mismatch($sformatf("status at 0x%04h (we %0b): got 0x%02h, expected 0x%02h",
                                adr, we, status, exp_status));
    end
    if (!we && exp_status == STATUS_ACK && rdata !== exp_rdata) begin
      report_mismatch($sformatf("read data at 0x%04h: got 0x%08h, expected 0x%08h",
                                adr, rdata, exp_rdata));
    end
    if (done_count - done_before != 1) begin
      report_mismatch($sformatf("%0d done pulses in one frame", done_count - done_before));
    end
    if (ext_seen != (is_ext ? 1 : 0)) begin
      report_failure($sformatf("External port saw %0d requests for address 0x%04h",
                               ext_seen, adr));
    end
    if (we && debug !== model_debug) begin
      report_mismatch($sformatf("debug_o: got 0x%08h, expected 0x%08h", debug, model_debug));
    end
  endtask

  // External slave with a delay, an error or no answer as set up per frame
  initial begin : ext_slave
    logic [7:0] idx;
    forever begin
      @(negedge sys_clk);
      if (ext_req.cyc && ext_req.stb) begin
        ext_seen = ext_seen + 1;
        idx = ext_req.adr[7:0];
        if (ext_expect && (ext_req.adr !== ext_exp_adr || ext_req.we !== ext_exp_we ||
                           ext_req.sel !== ext_exp_sel)) begin
          report_mismatch($sformatf({"ext request adr 0x%04h we %0b sel 0x%h, ",
                                     "expected 0x%04h %0b 0x%h"},
                                    ext_req.adr, ext_req.we, ext_req.sel,
                                    ext_exp_adr, ext_exp_we, ext_exp_sel));
        end
        if (ext_expect && ext_exp_we && ext_req.dat !== ext_exp_dat) begin
          report_mismatch($sformatf("ext write data: got 0x%08h, expected 0x%08h",
                                    ext_req.dat, ext_exp_dat));
        end
        if (ext_mode == EXT_HANG) begin
          while (ext_req.cyc) @(negedge sys_clk);
        end else begin
          repeat (ext_delay - 1) @(negedge sys_clk);
          if (ext_req.cyc) begin
            if (ext_mode == EXT_ERR) ext_rsp.err = 1'b1;
            else ext_rsp.ack = 1'b1;
            ext_rsp.dat = ext_mem[idx];
            if (ext_mode == EXT_ACK && ext_req.we) begin
              ext_mem[idx] = lane_write(ext_mem[idx], ext_req.dat, ext_req.sel);
            end
            @(negedge sys_clk);
            ext_rsp = '0;
          end
        end
      end
    end
  end

  always @(negedge sys_clk) begin
    if (cmd_done) done_count++;
    if (spi_cs_n && spi_miso !== 1'b0) report_mismatch("miso not 0 while cs_n is high");
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
    $display("Watchdog timeout: the test sequence did not finish in time");
    $display("Errors found");
    $finish;
  end

  initial begin : main
    logic        we;
    logic [3:0]  sel;
    logic [15:0] adr;
    logic [31:0] wdata;
    logic [7:0]  rx;
    int          pick;
    int          mode;
    int          done_before;
    void'($urandom(32'hf0e247af));
    reset    = 1'b1;
    spi_cs_n = 1'b1;
    spi_sclk = 1'b0;
    spi_mosi = 1'b0;
    ext_rsp  = '0;
    for (int i = 0; i < 256; i++) begin
      ext_mem[i]   = ext_fill(i);
      ext_model[i] = ext_fill(i);
    end
    repeat (2) @(negedge sys_clk);
    reset = 1'b0;
    repeat (2) @(negedge sys_clk);
    if (debug !== '0 || ext_req.cyc !== 1'b0 || cmd_done !== 1'b0 || spi_miso !== 1'b0) begin
      report_mismatch("outputs not cleared after reset");
    end

    run_access(1'b0, 4'hF, {8'h00, REG_ID}, '0, EXT_ACK);
    run_access(1'b0, 4'hF, {8'h00, REG_REV}, '0, EXT_ACK);
    run_access(1'b0, 4'hF, {8'h00, REG_SCRATCH}, '0, EXT_ACK);
    run_access(1'b1, 4'hF, {8'h00, REG_ID}, $urandom, EXT_ACK);
    run_access(1'b1, 4'hF, {8'h00, REG_REV}, $urandom, EXT_ACK);
    run_access(1'b0, 4'hF, {8'h00, REG_ID}, '0, EXT_ACK);
    run_access(1'b0, 4'hF, {8'h00, REG_REV}, '0, EXT_ACK);
    run_access(1'b1, 4'hF, 16'h00FF, $urandom, EXT_ACK);
    run_access(1'b0, 4'hF, 16'h0010, '0, EXT_ACK);

    for (int n = 0; n < 40; n++) begin
      sel   = 4'($urandom_range(15, 0));
      wdata = $urandom;
      adr   = {8'h00, ($urandom_range(1, 0) == 1) ? REG_DEBUG : REG_SCRATCH};
      run_access(1'b1, sel, adr, wdata, EXT_ACK);
      adr   = {8'h00, ($urandom_range(1, 0) == 1) ? REG_DEBUG : REG_SCRATCH};
      run_access(1'b0, 4'hF, adr, '0, EXT_ACK);
    end

    for (int n = 0; n < 40; n++) begin
      pick  = $urandom_range(7, 0);
      mode  = (pick == 0) ? EXT_HANG : (pick == 1) ? EXT_ERR : EXT_ACK;
      we    = 1'($urandom_range(1, 0));
      sel   = 4'($urandom_range(15, 0));
      adr   = EXT_BASE + 16'($urandom_range(15, 0)); // Small window so reads hit writes
      wdata = $urandom;
      run_access(we, sel, adr, wdata, mode);
    end
    run_access(1'b1, 4'hF, EXT_BASE + 16'h0020, 32'hDEAD_BEEF, EXT_HANG);
    run_access(1'b0, 4'hF, EXT_BASE + 16'h0020, '0, EXT_HANG);

    // Frame cut short after one address byte
    done_before = done_count;
    ext_seen    = 0;
    spi_cs_n    = 1'b0;
    repeat (4) @(negedge sys_clk);
    spi_byte(8'h8F, rx);
    spi_byte(8'h01, rx);
    repeat (4) @(negedge sys_clk);
    spi_cs_n = 1'b1;
    repeat (8) @(negedge sys_clk);
    if (done_count != done_before || ext_seen != 0) begin
      report_failure("Aborted frame produced a bus access or a done pulse");
    end

    for (int n = 0; n < 10; n++) begin
      we  = 1'($urandom_range(1, 0));
      adr = 16'($urandom_range(16'hFFFF, 16'h0200));
      run_access(we, 4'hF, adr, $urandom, EXT_ACK);
    end

    $display("Value mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- vlog.f
hdl/spi_wb_pkg.sv
hdl/spi_frame_shifter.sv
hdl/spi_bridge_fsm.sv
hdl/wb_timeout_timer.sv
hdl/wb_addr_decoder.sv
hdl/sys_block.sv
hdl/spi_wb_top.sv
dv/spi_wb_tb.sv

//--- Makefile
SIM_LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module spi_wb_top

sim:
	verilator --binary --timing -f vlog.f --top-module spi_wb_tb -Mdir obj_dir -o spi_wb_sim
	./obj_dir/spi_wb_sim > $(SIM_LOG)
	cat $(SIM_LOG)
	@if grep -q "Errors found" $(SIM_LOG); then \
	  echo "Simulation failed"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(SIM_LOG)
